// ==== design/hcost_pkg.sv ====
// Hadamard cost engine definitions
`default_nettype none

package hcost_pkg;

    // ------------------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------------------
    localparam int unsigned mem_words_lp   = 16;
    localparam int unsigned mem_aw_lp      = 4;
    localparam int unsigned data_w_lp      = 32;
    localparam int unsigned sample_w_lp    = 8;
    localparam int unsigned weight_w_lp    = 16;
    localparam int unsigned cost_w_lp      = 32;
    localparam int unsigned blk_elems_lp   = 16;
    localparam int unsigned paddr_w_lp     = 8;

    // Memory map in words
    localparam int unsigned sample_base_lp = 0;
    localparam int unsigned weight_base_lp = 4;
    localparam int unsigned fetch_words_lp = 12;

    // ------------------------------------------------------------------------
    // APB byte offsets
    // ------------------------------------------------------------------------
    localparam logic [paddr_w_lp-1:0] reg_ctrl_lp   = 8'h00;
    localparam logic [paddr_w_lp-1:0] reg_status_lp = 8'h04;
    localparam logic [paddr_w_lp-1:0] reg_result_lp = 8'h08;
    localparam logic [paddr_w_lp-1:0] win_base_lp   = 8'h40;

    // Engine sequencer
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_FETCH,
        ENG_CALC,
        ENG_WAIT
    } eng_state_t;

    // Window access FSM of the register block
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_MEM_REQ,
        APB_MEM_DATA
    } apb_state_t;

endpackage

`default_nettype wire

// ==== design/hcost_block_ram.sv ====
// Shared word memory
`default_nettype none

module hcost_block_ram import hcost_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 en_i,
    input  wire logic                 we_i,
    input  wire logic [mem_aw_lp-1:0] addr_i,
    input  wire logic [data_w_lp-1:0] wdata_i,
    output logic      [data_w_lp-1:0] rdata_o
);

    logic [data_w_lp-1:0] mem_q [mem_words_lp];

    // Only one granted access per cycle, read or write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_words_lp; i++) begin
                mem_q[i] <= '0;
            end
            rdata_o <= '0;
        end else if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/hcost_mem_arbiter.sv ====
// Round-robin memory arbiter
`default_nettype none

module hcost_mem_arbiter import hcost_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 req0_i,
    input  wire logic                 we0_i,
    input  wire logic [mem_aw_lp-1:0] addr0_i,
    input  wire logic [data_w_lp-1:0] wdata0_i,
    output logic                      gnt0_o,
    input  wire logic                 req1_i,
    input  wire logic                 we1_i,
    input  wire logic [mem_aw_lp-1:0] addr1_i,
    input  wire logic [data_w_lp-1:0] wdata1_i,
    output logic                      gnt1_o,
    output logic                      mem_en_o,
    output logic                      mem_we_o,
    output logic      [mem_aw_lp-1:0] mem_addr_o,
    output logic      [data_w_lp-1:0] mem_wdata_o
);

    // Set when port 1 won the last grant
    logic last1_q;

    // Port 0 wins a tie only when port 1 was served last
    assign gnt0_o = req0_i & (~req1_i | last1_q);
    assign gnt1_o = req1_i & (~req0_i | ~last1_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last1_q <= 1'b0;
        end else if (gnt0_o) begin
            last1_q <= 1'b0;
        end else if (gnt1_o) begin
            last1_q <= 1'b1;
        end
    end

    assign mem_en_o    = gnt0_o | gnt1_o;
    assign mem_we_o    = gnt0_o ? we0_i : (gnt1_o & we1_i);
    assign mem_addr_o  = gnt0_o ? addr0_i : addr1_i;
    assign mem_wdata_o = gnt0_o ? wdata0_i : wdata1_i;

    // A held request that loses is served on the next cycle
    a_no_starve0 : assert property (@(posedge clk) disable iff (!rst_n)
        req0_i && !gnt0_o |=> gnt0_o);
    a_no_starve1 : assert property (@(posedge clk) disable iff (!rst_n)
        req1_i && !gnt1_o |=> gnt1_o);

endmodule

`default_nettype wire

// ==== design/hcost_apb_regs.sv ====
// APB register block
`default_nettype none

module hcost_apb_regs import hcost_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [paddr_w_lp-1:0] paddr_i,
    input  wire logic [data_w_lp-1:0]  pwdata_i,
    output logic      [data_w_lp-1:0]  prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output logic      [mem_aw_lp-1:0]  mem_addr_o,
    output logic      [data_w_lp-1:0]  mem_wdata_o,
    input  wire logic                  mem_gnt_i,
    input  wire logic [data_w_lp-1:0]  mem_rdata_i,
    output logic                       run_o,
    input  wire logic                  busy_i,
    input  wire logic                  done_i,
    input  wire logic [cost_w_lp-1:0]  cost_i
);

    apb_state_t           state_q;
    logic                 done_q;
    logic [cost_w_lp-1:0] result_q;
    logic                 access;
    logic                 win_hit;
    logic                 reg_hit;
    logic                 win_done;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    assign access  = psel_i & penable_i;
    assign win_hit = paddr_i[paddr_w_lp-1:mem_aw_lp+2] ==
                     win_base_lp[paddr_w_lp-1:mem_aw_lp+2];
    assign reg_hit = (paddr_i == reg_ctrl_lp) | (paddr_i == reg_status_lp) |
                     (paddr_i == reg_result_lp);

    // Write completes on grant and read one cycle later with the data
    assign win_done = ((state_q == APB_MEM_REQ) & mem_gnt_i & pwrite_i) |
                      (state_q == APB_MEM_DATA);

    assign pready_o  = access & (~win_hit | win_done);
    assign pslverr_o = access & ~win_hit & ~reg_hit;

    assign run_o = access & pwrite_i & (paddr_i == reg_ctrl_lp) & pwdata_i[0];

    always_comb begin
        prdata_o = '0;
        if (state_q == APB_MEM_DATA) begin
            prdata_o = mem_rdata_i;
        end else if (access & ~pwrite_i) begin
            if (paddr_i == reg_status_lp) begin
                prdata_o = {{(data_w_lp-2){1'b0}}, done_q, busy_i};
            end else if (paddr_i == reg_result_lp) begin
                prdata_o = result_q;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Window FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= APB_IDLE;
        end else begin
            case (state_q)
                APB_IDLE: begin
                    if (access & win_hit) begin
                        state_q <= APB_MEM_REQ;
                    end
                end
                APB_MEM_REQ: begin
                    if (mem_gnt_i) begin
                        state_q <= pwrite_i ? APB_IDLE : APB_MEM_DATA;
                    end
                end
                default: state_q <= APB_IDLE;
            endcase
        end
    end

    // Host holds the transfer stable while waiting
    assign mem_req_o   = (state_q == APB_MEM_REQ);
    assign mem_we_o    = pwrite_i;
    assign mem_addr_o  = paddr_i[mem_aw_lp+1:2];
    assign mem_wdata_o = pwdata_i;

    // Sticky done bit is cleared only by an accepted run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q   <= 1'b0;
            result_q <= '0;
        end else if (done_i) begin
            done_q   <= 1'b1;
            result_q <= cost_i;
        end else if (run_o & ~busy_i) begin
            done_q <= 1'b0;
        end
    end

    // Window FSM only leaves idle inside a held window access phase
    a_win_held : assert property (@(posedge clk) disable iff (!rst_n)
        (state_q != APB_IDLE) |-> (access && win_hit));

endmodule

`default_nettype wire

// ==== design/hcost_engine.sv ====
// Cost engine fetch sequencer
`default_nettype none

module hcost_engine import hcost_pkg::*; (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                run_i,
    output logic                                     busy_o,
    output logic                                     done_o,
    output logic      [cost_w_lp-1:0]                cost_o,
    output logic                                     mem_req_o,
    output logic      [mem_aw_lp-1:0]                mem_addr_o,
    input  wire logic                                mem_gnt_i,
    input  wire logic [data_w_lp-1:0]                mem_rdata_i,
    output logic                                     hd_start_o,
    output logic      [blk_elems_lp*sample_w_lp-1:0] hd_samples_o,
    output logic      [blk_elems_lp*weight_w_lp-1:0] hd_weights_o,
    input  wire logic                                hd_done_i,
    input  wire logic [cost_w_lp-1:0]                hd_cost_i
);

    eng_state_t           state_q;
    logic [mem_aw_lp-1:0] word_cnt_q;
    logic [mem_aw_lp-1:0] pend_idx_q;
    logic                 pend_q;
    logic [data_w_lp-1:0] fetch_q [fetch_words_lp];

    assign mem_req_o  = (state_q == ENG_FETCH) && (word_cnt_q < fetch_words_lp);
    assign mem_addr_o = mem_aw_lp'(sample_base_lp + word_cnt_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ENG_IDLE;
            word_cnt_q <= '0;
            pend_idx_q <= '0;
            pend_q     <= 1'b0;
        end else begin
            case (state_q)
                ENG_IDLE: begin
                    word_cnt_q <= '0;
                    pend_q     <= 1'b0;
                    if (run_i) begin
                        state_q <= ENG_FETCH;
                    end
                end
                ENG_FETCH: begin
                    // Next request overlaps the capture of the previous word
                    pend_q <= mem_gnt_i;
                    if (mem_gnt_i) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        pend_idx_q <= word_cnt_q;
                    end
                    if (pend_q && (word_cnt_q == fetch_words_lp)) begin
                        state_q <= ENG_CALC;
                    end
                end
                ENG_CALC: state_q <= ENG_WAIT;
                ENG_WAIT: begin
                    if (hd_done_i) begin
                        state_q <= ENG_IDLE;
                    end
                end
                default: state_q <= ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pend_q) begin
            fetch_q[pend_idx_q] <= mem_rdata_i;
        end
    end

    // Sample rows first, then packed weight pairs
    for (genvar i = 0; i < weight_base_lp; i++) begin : g_samples
        assign hd_samples_o[i*data_w_lp +: data_w_lp] = fetch_q[i];
    end
    for (genvar i = 0; i < fetch_words_lp - weight_base_lp; i++) begin : g_weights
        assign hd_weights_o[i*data_w_lp +: data_w_lp] = fetch_q[weight_base_lp + i];
    end

    assign hd_start_o = (state_q == ENG_CALC);
    assign busy_o     = (state_q != ENG_IDLE);
    assign done_o     = (state_q == ENG_WAIT) & hd_done_i;
    assign cost_o     = hd_cost_i;

    a_start_done : assert property (@(posedge clk) disable iff (!rst_n)
        hd_start_o |-> ##2 hd_done_i);

endmodule

`default_nettype wire

// ==== design/hcost_hadamard.sv ====
// Weighted 4x4 Hadamard cost
`default_nettype none

module hcost_hadamard import hcost_pkg::*; (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                start_i,
    input  wire logic [blk_elems_lp*sample_w_lp-1:0] samples_i,
    input  wire logic [blk_elems_lp*weight_w_lp-1:0] weights_i,
    output logic                                     done_o,
    output logic      [cost_w_lp-1:0]                cost_o
);

    logic signed [10:0]            row_c [blk_elems_lp];
    logic signed [12:0]            col_c [blk_elems_lp];
    logic        [11:0]            abs_q [blk_elems_lp];
    logic signed [weight_w_lp-1:0] w_q   [blk_elems_lp];
    logic signed [cost_w_lp-1:0]   sum;
    logic        [1:0]             start_sr_q;

    // ------------------------------------------------------------------------
    // Butterflies, rows then columns
    // ------------------------------------------------------------------------
    for (genvar r = 0; r < 4; r++) begin : g_row
        logic signed [10:0] x [4];
        logic signed [10:0] a0, a1, a2, a3;
        for (genvar c = 0; c < 4; c++) begin : g_x
            assign x[c] = $signed({3'b000, samples_i[(4*r+c)*sample_w_lp +: sample_w_lp]});
        end
        assign a0 = x[0] + x[2];
        assign a1 = x[1] + x[3];
        assign a2 = x[1] - x[3];
        assign a3 = x[0] - x[2];
        assign row_c[4*r+0] = a0 + a1;
        assign row_c[4*r+1] = a3 + a2;
        assign row_c[4*r+2] = a3 - a2;
        assign row_c[4*r+3] = a0 - a1;
    end

    for (genvar c = 0; c < 4; c++) begin : g_col
        logic signed [12:0] b0, b1, b2, b3;
        assign b0 = row_c[c] + row_c[8+c];
        assign b1 = row_c[4+c] + row_c[12+c];
        assign b2 = row_c[4+c] - row_c[12+c];
        assign b3 = row_c[c] - row_c[8+c];
        assign col_c[c]    = b0 + b1;
        assign col_c[4+c]  = b3 + b2;
        assign col_c[8+c]  = b3 - b2;
        assign col_c[12+c] = b0 - b1;
    end

    // Stage 1: magnitudes, weights held alongside
    always_ff @(posedge clk) begin
        for (int i = 0; i < blk_elems_lp; i++) begin
            abs_q[i] <= 12'((col_c[i] < 0) ? -col_c[i] : col_c[i]);
            w_q[i]   <= $signed(weights_i[i*weight_w_lp +: weight_w_lp]);
        end
    end

    // Stage 2: weighted sum, wraps at the cost width
    always_comb begin
        sum = '0;
        for (int i = 0; i < blk_elems_lp; i++) begin
            sum = sum + signed'(cost_w_lp'(abs_q[i])) * cost_w_lp'(w_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        cost_o <= sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_sr_q <= '0;
        end else begin
            start_sr_q <= {start_sr_q[0], start_i};
        end
    end

    assign done_o = start_sr_q[1];

endmodule

`default_nettype wire

// ==== design/hcost_top.sv ====
// Hadamard cost subsystem top
`default_nettype none

module hcost_top import hcost_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [paddr_w_lp-1:0] paddr_i,
    input  wire logic [data_w_lp-1:0]  pwdata_i,
    output logic      [data_w_lp-1:0]  prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);

    logic                                reg_req, reg_we, reg_gnt;
    logic [mem_aw_lp-1:0]                reg_addr;
    logic [data_w_lp-1:0]                reg_wdata;
    logic                                eng_req, eng_gnt;
    logic [mem_aw_lp-1:0]                eng_addr;
    logic                                mem_en, mem_we;
    logic [mem_aw_lp-1:0]                mem_addr;
    logic [data_w_lp-1:0]                mem_wdata, mem_rdata;
    logic                                run, busy, done;
    logic [cost_w_lp-1:0]                cost, hd_cost;
    logic                                hd_start, hd_done;
    logic [blk_elems_lp*sample_w_lp-1:0] hd_samples;
    logic [blk_elems_lp*weight_w_lp-1:0] hd_weights;

    hcost_apb_regs i_regs (
        .clk, .rst_n, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .mem_req_o(reg_req), .mem_we_o(reg_we), .mem_addr_o(reg_addr),
        .mem_wdata_o(reg_wdata), .mem_gnt_i(reg_gnt), .mem_rdata_i(mem_rdata),
        .run_o(run), .busy_i(busy), .done_i(done), .cost_i(cost)
    );

    // Engine only reads
    hcost_mem_arbiter i_arbiter (
        .clk, .rst_n,
        .req0_i(reg_req), .we0_i(reg_we), .addr0_i(reg_addr), .wdata0_i(reg_wdata),
        .gnt0_o(reg_gnt),
        .req1_i(eng_req), .we1_i(1'b0), .addr1_i(eng_addr), .wdata1_i('0),
        .gnt1_o(eng_gnt),
        .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata)
    );

    hcost_block_ram i_ram (
        .clk, .rst_n, .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
        .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

    hcost_engine i_engine (
        .clk, .rst_n, .run_i(run), .busy_o(busy), .done_o(done), .cost_o(cost),
        .mem_req_o(eng_req), .mem_addr_o(eng_addr), .mem_gnt_i(eng_gnt),
        .mem_rdata_i(mem_rdata), .hd_start_o(hd_start), .hd_samples_o(hd_samples),
        .hd_weights_o(hd_weights), .hd_done_i(hd_done), .hd_cost_i(hd_cost)
    );

    hcost_hadamard i_hadamard (
        .clk, .rst_n, .start_i(hd_start), .samples_i(hd_samples),
        .weights_i(hd_weights), .done_o(hd_done), .cost_o(hd_cost)
    );

endmodule

`default_nettype wire

// ==== test/hcost_tb.sv ====
// Hadamard cost subsystem testbench
`default_nettype none

module hcost_tb import hcost_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_random_lp    = 40;
    localparam int n_corner_lp    = 4;
    localparam int iterations_lp  = n_random_lp + n_corner_lp + 10;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [paddr_w_lp-1:0] paddr;
    logic [data_w_lp-1:0]  pwdata;
    logic [data_w_lp-1:0]  prdata;
    logic                  pready;
    logic                  pslverr;

    logic        [sample_w_lp-1:0] smp       [blk_elems_lp];
    logic signed [weight_w_lp-1:0] wgt       [blk_elems_lp];
    logic        [data_w_lp-1:0]   mem_model [mem_words_lp];
    logic        [cost_w_lp-1:0]   got_q [$];
    logic        [cost_w_lp-1:0]   exp_q [$];
    int                            err_cnt = 0;

    hcost_top i_hcost_top (
        .clk, .rst_n, .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
        .pready_o(pready), .pslverr_o(pslverr)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model and checking
    // ------------------------------------------------------------------------

    // Sequency-ordered 4x4 Walsh-Hadamard, coefficient index is 4*u+v
    function automatic int hadamard_cost();
        int basis [4][4] = '{'{1, 1, 1, 1}, '{1, 1, -1, -1},
                             '{1, -1, -1, 1}, '{1, -1, 1, -1}};
        int coef;
        int acc;
        acc = 0;
        for (int u = 0; u < 4; u++) begin
            for (int v = 0; v < 4; v++) begin
                coef = 0;
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        coef += basis[u][r] * basis[v][c] * int'(smp[4*r+c]);
                    end
                end
                if (coef < 0) begin
                    coef = -coef;
                end
                acc += coef * int'(wgt[4*u+v]);
            end
        end
        return acc;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Compares each returned cost with its reference
    always @(posedge clk) begin
        if (got_q.size() != 0 && exp_q.size() != 0) begin
            check_value(got_q.pop_front(), exp_q.pop_front(), "RESULT");
        end
    end

    // ------------------------------------------------------------------------
    // APB driver
    // ------------------------------------------------------------------------
    task automatic write_word(input logic [paddr_w_lp-1:0] addr,
                              input logic [data_w_lp-1:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(posedge clk);
        end while (pready !== 1'b1);
        err = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_word(input logic [paddr_w_lp-1:0] addr,
                             output logic [data_w_lp-1:0] data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(posedge clk);
        end while (pready !== 1'b1);
        data = prdata;
        err  = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic [paddr_w_lp-1:0] window_addr(input int w);
        return paddr_w_lp'(win_base_lp + 4 * w);
    endfunction

    // Rows of samples, then packed weight pairs
    task automatic load_block();
        logic [data_w_lp-1:0] word;
        logic                 err;
        for (int r = 0; r < 4; r++) begin
            word = {smp[4*r+3], smp[4*r+2], smp[4*r+1], smp[4*r]};
            mem_model[sample_base_lp + r] = word;
            write_word(window_addr(sample_base_lp + r), word, err);
        end
        for (int k = 0; k < 8; k++) begin
            word = {wgt[2*k+1], wgt[2*k]};
            mem_model[weight_base_lp + k] = word;
            write_word(window_addr(weight_base_lp + k), word, err);
        end
    endtask

    task automatic run_block();
        logic [data_w_lp-1:0] status;
        logic [data_w_lp-1:0] result;
        logic                 err;
        write_word(reg_ctrl_lp, 32'h1, err);
        do begin
            read_word(reg_status_lp, status, err);
        end while (status[1] !== 1'b1);
        read_word(reg_result_lp, result, err);
        got_q.push_back(result);
        exp_q.push_back(hadamard_cost());
    endtask

    task automatic set_corner(input int kind);
        logic [sample_w_lp-1:0] board;
        for (int i = 0; i < blk_elems_lp; i++) begin
            board = (((i / 4) + (i % 4)) % 2 == 1) ? 8'hff : 8'h00;
            case (kind)
                0: begin
                    smp[i] = 8'h00;
                    wgt[i] = 16'h7fff;
                end
                1: begin
                    smp[i] = 8'hff;
                    wgt[i] = 16'h8000;
                end
                2: begin
                    smp[i] = board;
                    wgt[i] = 16'h7fff;
                end
                default: begin
                    smp[i] = board;
                    wgt[i] = (i % 2 == 1) ? 16'h8000 : 16'h7fff;
                end
            endcase
        end
    endtask

    task automatic randomize_block();
        for (int i = 0; i < blk_elems_lp; i++) begin
            smp[i] = 8'($urandom);
            wgt[i] = 16'($urandom);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [data_w_lp-1:0] data;
        logic [data_w_lp-1:0] status;
        logic                 err;
        int                   k;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rst_n   = 1'b0;
        void'($urandom(32'h49b8));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value(pready, 1'b0, "pready after reset");
        check_value(pslverr, 1'b0, "pslverr after reset");

        // Reset values and unmapped addresses
        read_word(reg_status_lp, data, err);
        check_value(data, 0, "STATUS after reset");
        read_word(reg_result_lp, data, err);
        check_value(data, 0, "RESULT after reset");
        read_word(reg_ctrl_lp, data, err);
        check_value(data, 0, "CTRL after reset");
        check_value(err, 1'b0, "pslverr on CTRL");
        read_word(8'h0c, data, err);
        check_value(err, 1'b1, "pslverr on read of 0x0C");
        write_word(8'h80, 32'h1234, err);
        check_value(err, 1'b1, "pslverr on write of 0x80");

        // Window write and read back
        for (int w = 0; w < mem_words_lp; w++) begin
            mem_model[w] = $urandom;
            write_word(window_addr(w), mem_model[w], err);
        end
        for (int w = 0; w < mem_words_lp; w++) begin
            read_word(window_addr(w), data, err);
            check_value(data, mem_model[w], "window read back");
        end

        for (int n = 0; n < n_random_lp; n++) begin
            randomize_block();
            load_block();
            run_block();
        end

        for (int n = 0; n < n_corner_lp; n++) begin
            set_corner(n);
            load_block();
            run_block();
        end

        // Second run request while busy
        randomize_block();
        load_block();
        write_word(reg_ctrl_lp, 32'h1, err);
        read_word(reg_status_lp, status, err);
        check_value(status, 32'h1, "STATUS busy after run request");
        write_word(reg_ctrl_lp, 32'h1, err);
        do begin
            read_word(reg_status_lp, status, err);
        end while (status[1] !== 1'b1);
        check_value(status, 32'h2, "STATUS at done");
        read_word(reg_result_lp, data, err);
        got_q.push_back(data);
        exp_q.push_back(hadamard_cost());
        repeat (20) @(posedge clk);
        read_word(reg_status_lp, status, err);
        check_value(status, 32'h2, "STATUS after ignored request");

        // Host window reads contend with the engine fetch
        randomize_block();
        load_block();
        write_word(reg_ctrl_lp, 32'h1, err);
        k = 0;
        do begin
            read_word(window_addr(k), data, err);
            check_value(data, mem_model[k], "window read during run");
            k = (k + 1) % mem_words_lp;
            read_word(reg_status_lp, status, err);
        end while (status[1] !== 1'b1);
        read_word(reg_result_lp, data, err);
        got_q.push_back(data);
        exp_q.push_back(hadamard_cost());

        while (got_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("Finished with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Budget of 200 cycles per iteration
    initial begin
        repeat (iterations_lp * 200) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 iterations_lp * 200);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/hcost_pkg.sv
design/hcost_block_ram.sv
design/hcost_mem_arbiter.sv
design/hcost_apb_regs.sv
design/hcost_engine.sv
design/hcost_hadamard.sv
design/hcost_top.sv
test/hcost_tb.sv

// ==== Bender.yml ====
package:
  name: hcost

sources:
  - design/hcost_pkg.sv
  - design/hcost_block_ram.sv
  - design/hcost_mem_arbiter.sv
  - design/hcost_apb_regs.sv
  - design/hcost_engine.sv
  - design/hcost_hadamard.sv
  - design/hcost_top.sv
  - target: test
    files:
      - test/hcost_tb.sv
